/* vlog.f */
hdl/mxu_pkg.sv
hdl/mxu_ctrl_pkg.sv
hdl/result_wr_if.sv
hdl/mxu_ctrl.sv
hdl/act_skewer.sv
hdl/mac_pe.sv
hdl/systolic_array.sv
hdl/result_writer.sv
hdl/result_mem.sv
hdl/mxu_top.sv
bench/mxu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the MXU testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mxu_tb -f vlog.f -o mxu_sim \
  && ./obj_dir/mxu_sim | tee sim.log \
  && ! grep -q "Result: FAILED" sim.log \
  && grep -q "Result: PASSED" sim.log \
  || exit 1

/* bench/mxu_tb.sv */
// MXU testbench
// loads weight matrices, streams activation rows and checks every result
// row against a reference matrix product, along with busy and done timing

module mxu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n = mxu_pkg::array_n;
  localparam logic [31:0] seed = 32'haf4c_aa88;
  localparam int clk_half = 50;
  localparam int done_latency = 3 * n + 1;   // first strobe to done
  localparam int num_runs = 2;               // random computes in the random test
  localparam int num_tests = 6;              // reset read plus five computes
  localparam int cycles_per_test = 80;       // load, stream, drain and a full readback
  localparam int watchdog_cycles = num_tests * cycles_per_test + 100;

  typedef mxu_pkg::data_row_t mat_t [n];

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic cmd_valid;
  mxu_ctrl_pkg::mxu_op_e cmd_op;
  logic [$clog2(n)-1:0] cmd_row;
  mxu_pkg::data_row_t cmd_data;
  logic [mxu_pkg::addr_w-1:0] cmd_base;
  logic [mxu_pkg::addr_w-1:0] rd_addr;
  mxu_pkg::acc_row_t rd_data;
  logic busy;
  logic done;

  mat_t w_model;                                     // weights the DUT should hold
  mxu_pkg::acc_row_t exp_mem [1 << mxu_pkg::addr_w]; // expected result store
  string test_name;
  int cyc;
  int start_cyc;                                     // cycle of the first stream strobe
  int issued_cnt;
  int checked_cnt;
  int checks;
  int value_errs;
  int proto_errs;
  bit reset_done;
  bit init_checked;

  mxu_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_row   (cmd_row),
    .cmd_data  (cmd_data),
    .cmd_base  (cmd_base),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .busy      (busy),
    .done      (done)
  );

  always #clk_half clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // row times matrix kept to the low acc_w bits of the signed sums
  function automatic mxu_pkg::acc_row_t ref_matmul(mxu_pkg::data_row_t act, mat_t w);
    mxu_pkg::acc_row_t res;
    int sum;
    for (int j = 0; j < n; j++) begin
      sum = 0;
      for (int i = 0; i < n; i++) begin
        sum += int'($signed(act[i])) * int'($signed(w[i][j]));
      end
      res[j] = sum[mxu_pkg::acc_w-1:0];
    end
    return res;
  endfunction

  function automatic mxu_pkg::data_row_t rand_row();
    mxu_pkg::data_row_t r;
    logic [31:0] tmp;
    for (int i = 0; i < n; i++) begin
      tmp = $urandom;
      r[i] = tmp[mxu_pkg::data_w-1:0];
    end
    return r;
  endfunction

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      value_errs++;
      $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic load_weights(input mat_t w);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #5;
      cmd_valid = 1'b1;
      cmd_op    = mxu_ctrl_pkg::op_load_w;
      cmd_row   = i[$clog2(n)-1:0];
      cmd_data  = w[i];
    end
    @(posedge clk);
    #5;
    cmd_valid = 1'b0;
  endtask

  // four strobes on back-to-back cycles
  task automatic stream_rows(input mat_t acts, input int base);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #5;
      if (k == 0) start_cyc = cyc;
      cmd_valid = 1'b1;
      cmd_op    = mxu_ctrl_pkg::op_stream;
      cmd_base  = base[mxu_pkg::addr_w-1:0];
      cmd_data  = acts[k];
    end
    @(posedge clk);
    #5;
    cmd_valid = 1'b0;
    cmd_data  = '0;
  endtask

  task automatic read_row(input int addr, output mxu_pkg::acc_row_t got);
    @(posedge clk);
    #5;
    rd_addr = addr[mxu_pkg::addr_w-1:0];
    @(posedge clk);
    #1;
    got = rd_data;
  endtask

  task automatic check_rows();
    mxu_pkg::acc_row_t got;
    for (int r = 0; r < (1 << mxu_pkg::addr_w); r++) begin
      read_row(r, got);
      checks++;
      assert (got == exp_mem[r]) else begin
        value_errs++;
        $display("Fail %s row %0d: expected %h, actual %h", test_name, r, exp_mem[r], got);
      end
    end
  endtask

  // busy_loads sends a weight set while the compute is running
  task automatic run_compute(input string name, input mat_t acts, input int base,
                             input bit busy_loads);
    mat_t junk;
    test_name = name;
    for (int k = 0; k < n; k++) exp_mem[base + k] = ref_matmul(acts[k], w_model);
    stream_rows(acts, base);
    issued_cnt++;
    if (busy_loads) begin
      for (int i = 0; i < n; i++) junk[i] = rand_row();
      load_weights(junk);
    end
    wait (checked_cnt == issued_cnt);
  endtask

  initial begin : compare
    bit got_done;
    int waited;
    rd_addr = '0;
    wait (reset_done);
    check_rows();                    // result store starts cleared
    init_checked = 1'b1;
    forever begin
      wait (issued_cnt > checked_cnt);
      got_done = 1'b0;
      waited = 0;
      while (!got_done && waited < 4 * done_latency) begin
        @(posedge clk);
        #1;
        waited++;
        got_done = done;
        check_flag("busy", (cyc - start_cyc) < done_latency, busy);
      end
      assert (got_done) else begin
        proto_errs++;
        $display("%s: done never rose after the activation rows were streamed", test_name);
      end
      if (got_done) begin
        checks++;
        assert (cyc - start_cyc == done_latency) else begin
          value_errs++;
          $display("Fail %s done latency: expected %0d, actual %0d",
                   test_name, done_latency, cyc - start_cyc);
        end
      end
      check_rows();
      checked_cnt++;
    end
  end

  initial begin : stimulus
    mat_t acts;
    void'($urandom(seed));
    cmd_valid = 1'b0;
    cmd_op    = mxu_ctrl_pkg::op_load_w;
    cmd_row   = '0;
    cmd_data  = '0;
    cmd_base  = '0;
    for (int r = 0; r < (1 << mxu_pkg::addr_w); r++) exp_mem[r] = '0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    #5;
    reset = 1'b0;
    reset_done = 1'b1;
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    wait (init_checked);

    // identity weights pass each activation through
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) w_model[i][j] = (i == j) ? 8'sd1 : 8'sd0;
      acts[i] = rand_row();
    end
    load_weights(w_model);
    run_compute("identity", acts, 0, 1'b0);

    for (int run = 0; run < num_runs; run++) begin
      for (int i = 0; i < n; i++) begin
        w_model[i] = rand_row();
        acts[i] = rand_row();
      end
      w_model[0] = {n{8'h80}};       // most negative weights and activations
      acts[0] = {n{8'h80}};
      acts[n-1][0] = 8'h7f;
      load_weights(w_model);
      run_compute("random", acts, 4 + 8 * run, 1'b0);
    end

    // same weights into the second region of the store
    for (int k = 0; k < n; k++) acts[k] = rand_row();
    run_compute("second_base", acts, 8, 1'b0);

    test_name = "reload";
    repeat (3) @(posedge clk);
    #1;
    check_flag("done held", 1'b1, done);
    for (int i = 0; i < n; i++) begin
      w_model[i] = rand_row();
      acts[i] = rand_row();
    end
    load_weights(w_model);
    check_flag("done cleared", 1'b0, done);
    run_compute("reload", acts, 0, 1'b1);

    $display("checks %0d, value errors %0d, protocol errors %0d",
             checks, value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cycles * 2 * clk_half);
    $display("watchdog expired at cycle %0d before the tests finished", cyc);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* hdl/mxu_top.sv */
// Matrix unit top level
// 4x4 weight-stationary systolic multiplier with host command port
// and a result memory read port

module mxu_top (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 cmd_valid,
  input  mxu_ctrl_pkg::mxu_op_e                cmd_op,
  input  logic [$clog2(mxu_pkg::array_n)-1:0]  cmd_row,
  input  mxu_pkg::data_row_t                   cmd_data,
  input  logic [mxu_pkg::addr_w-1:0]           cmd_base,
  input  logic [mxu_pkg::addr_w-1:0]           rd_addr,
  output mxu_pkg::acc_row_t                    rd_data,
  output logic                                 busy,
  output logic                                 done
);

  logic                                 load_en;
  logic [$clog2(mxu_pkg::array_n)-1:0]  load_row;
  logic                                 row_valid;
  logic                                 wave_start;
  logic                                 wave_done;
  logic [mxu_pkg::addr_w-1:0]           base_addr;
  logic                                 cmd_seen;
  mxu_pkg::data_row_t                   skewed;
  mxu_pkg::acc_row_t                    bottom;

  result_wr_if wr_bus ();

  mxu_ctrl ctrl (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_row    (cmd_row),
    .cmd_base   (cmd_base),
    .wave_done  (wave_done),
    .load_en    (load_en),
    .load_row   (load_row),
    .row_valid  (row_valid),
    .wave_start (wave_start),
    .base_addr  (base_addr),
    .cmd_seen   (cmd_seen),
    .busy       (busy)
  );

  act_skewer skew (
    .clk       (clk),
    .reset     (reset),
    .row_valid (row_valid),
    .row_in    (cmd_data),
    .skew_out  (skewed)
  );

  // weights share the command data bus with activations
  systolic_array array (
    .clk      (clk),
    .reset    (reset),
    .load_en  (load_en),
    .load_row (load_row),
    .w_row    (cmd_data),
    .a_col    (skewed),
    .bottom   (bottom)
  );

  result_writer writer (
    .clk        (clk),
    .reset      (reset),
    .wave_start (wave_start),
    .base_addr  (base_addr),
    .cmd_seen   (cmd_seen),
    .bottom     (bottom),
    .wave_done  (wave_done),
    .done       (done),
    .wr         (wr_bus.writer)
  );

  result_mem mem (
    .clk     (clk),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr      (wr_bus.memory)
  );

endmodule

/* hdl/result_mem.sv */
// Result memory
// one word array per array column with its own write enable and
// address, read back a whole row at a time with one cycle latency

module result_mem (
  input  logic                        clk,
  input  logic [mxu_pkg::addr_w-1:0]  rd_addr,
  output mxu_pkg::acc_row_t           rd_data,
  result_wr_if.memory                 wr
);

  genvar j;

  generate
    for (j = 0; j < mxu_pkg::array_n; j++) begin : g_col
      logic [mxu_pkg::acc_w-1:0] words [1 << mxu_pkg::addr_w];

      always_ff @(posedge clk) begin
        if (wr.clear) begin
          for (int r = 0; r < (1 << mxu_pkg::addr_w); r++) begin
            words[r] <= '0;
          end
        end else if (wr.wr_en[j]) begin
          words[wr.wr_addr[j]] <= wr.wr_data[j]; // columns write on different cycles
        end
      end

      // registered read port
      always_ff @(posedge clk) begin
        rd_data[j] <= words[rd_addr];
      end
    end
  endgenerate

endmodule

/* hdl/result_writer.sv */
// Result writer
// walks the diagonal result wavefront into the column memories: the
// per-column enables ramp up then shift out, each column's row address
// steps with its enable, and done holds until the next host command

module result_writer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        wave_start,
  input  logic [mxu_pkg::addr_w-1:0]  base_addr,
  input  logic                        cmd_seen,
  input  mxu_pkg::acc_row_t           bottom,
  output logic                        wave_done,
  output logic                        done,
  result_wr_if.writer                 wr
);

  logic [mxu_pkg::array_n-1:0]                      wr_en;
  logic [mxu_pkg::array_n-1:0][mxu_pkg::addr_w-1:0] wr_addr;
  logic                                             ramp_dn; // enables are shifting out
  logic                                             clear;

  // only the last column still writing
  assign wave_done = ramp_dn && (wr_en == {1'b1, {(mxu_pkg::array_n-1){1'b0}}});

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en   <= '0;
      wr_addr <= '0;
      ramp_dn <= 1'b0;
      done    <= 1'b0;
      clear   <= 1'b1;   // wipe the result store coming out of reset
    end else begin
      clear <= 1'b0;
      if (wave_start) begin
        wr_en   <= {{(mxu_pkg::array_n-1){1'b0}}, 1'b1}; // column 0 first
        ramp_dn <= 1'b0;
        for (int j = 0; j < mxu_pkg::array_n; j++) begin
          wr_addr[j] <= base_addr;
        end
      end else if (|wr_en) begin
        if (ramp_dn || (&wr_en)) begin
          wr_en   <= wr_en << 1;   // drop the lowest column
          ramp_dn <= 1'b1;
        end else begin
          wr_en <= (wr_en << 1) | 1'b1; // bring in the next column
        end
        for (int j = 0; j < mxu_pkg::array_n; j++) begin
          wr_addr[j] <= wr_addr[j] + mxu_pkg::addr_w'(wr_en[j]);
        end
        if (wave_done) ramp_dn <= 1'b0;
      end

      // a new command wins over a finishing wave
      if (cmd_seen)       done <= 1'b0;
      else if (wave_done) done <= 1'b1;
    end
  end

  assign wr.wr_en   = wr_en;
  assign wr.wr_addr = wr_addr;
  assign wr.wr_data = bottom;   // bottom register lines up with the enables
  assign wr.clear   = clear;

endmodule

/* hdl/systolic_array.sv */
// Weight-stationary systolic array
// array_n x array_n grid of MAC cells; activations flow right, sums flow
// down, and the bottom row of sums is registered once more

module systolic_array (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 load_en,
  input  logic [$clog2(mxu_pkg::array_n)-1:0]  load_row,
  input  mxu_pkg::data_row_t                   w_row,
  input  mxu_pkg::data_row_t                   a_col,
  output mxu_pkg::acc_row_t                    bottom
);

  // a_h[i][j] feeds cell (i,j) from the left, ps_v[i][j] from above
  logic signed [mxu_pkg::data_w-1:0] a_h  [mxu_pkg::array_n][mxu_pkg::array_n+1];
  logic signed [mxu_pkg::acc_w-1:0]  ps_v [mxu_pkg::array_n+1][mxu_pkg::array_n];

  genvar i, j;

  generate
    for (i = 0; i < mxu_pkg::array_n; i++) begin : g_row
      logic w_load;

      assign w_load   = load_en && (load_row == i); // one weight row per load
      assign a_h[i][0] = a_col[i];

      for (j = 0; j < mxu_pkg::array_n; j++) begin : g_col
        if (i == 0) begin : g_top
          assign ps_v[0][j] = '0;
        end

        mac_pe pe (
          .clk      (clk),
          .reset    (reset),
          .w_load   (w_load),
          .w_in     (w_row[j]),
          .a_in     (a_h[i][j]),
          .psum_in  (ps_v[i][j]),
          .a_out    (a_h[i][j+1]),
          .psum_out (ps_v[i+1][j])
        );
      end
    end

    // output stage under the last row
    for (j = 0; j < mxu_pkg::array_n; j++) begin : g_bottom
      always_ff @(posedge clk) begin
        if (reset) bottom[j] <= '0;
        else       bottom[j] <= ps_v[mxu_pkg::array_n][j];
      end
    end
  endgenerate

endmodule

/* hdl/mac_pe.sv */
// Multiply-accumulate cell
// holds one weight, passes the activation right and the
// running column sum down, one register stage each

module mac_pe (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               w_load,
  input  logic signed [mxu_pkg::data_w-1:0]  w_in,
  input  logic signed [mxu_pkg::data_w-1:0]  a_in,
  input  logic signed [mxu_pkg::acc_w-1:0]   psum_in,
  output logic signed [mxu_pkg::data_w-1:0]  a_out,
  output logic signed [mxu_pkg::acc_w-1:0]   psum_out
);

  logic signed [mxu_pkg::data_w-1:0]   w_reg;
  logic signed [2*mxu_pkg::data_w-1:0] prod;

  assign prod = a_in * w_reg; // full signed product

  always_ff @(posedge clk) begin
    if (reset) begin
      w_reg    <= '0;
      a_out    <= '0;
      psum_out <= '0;
    end else begin
      if (w_load) w_reg <= w_in;
      a_out    <= a_in;
      psum_out <= psum_in + prod; // prod sign-extends to acc_w
    end
  end

endmodule

/* hdl/act_skewer.sv */
// Activation skew stage
// delays element i of each streamed row by i+1 cycles so the rows
// enter the array as a diagonal wavefront

module act_skewer (
  input  logic               clk,
  input  logic               reset,
  input  logic               row_valid,
  input  mxu_pkg::data_row_t row_in,
  output mxu_pkg::data_row_t skew_out
);

  genvar i;

  generate
    for (i = 0; i < mxu_pkg::array_n; i++) begin : g_lane
      // lane i is a shift register of depth i+1
      logic [mxu_pkg::data_w-1:0] taps [i+1];

      always_ff @(posedge clk) begin
        if (reset) begin
          for (int k = 0; k <= i; k++) begin
            taps[k] <= '0;
          end
        end else begin
          taps[0] <= row_valid ? row_in[i] : '0; // zeros between computes
          for (int k = 1; k <= i; k++) begin
            taps[k] <= taps[k-1];
          end
        end
      end

      assign skew_out[i] = taps[i];
    end
  endgenerate

endmodule

/* hdl/mxu_ctrl.sv */
// MXU controller
// decodes host commands, counts the streamed rows and sequences the
// stream, drain and write phases of one compute

module mxu_ctrl (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 cmd_valid,
  input  mxu_ctrl_pkg::mxu_op_e                cmd_op,
  input  logic [$clog2(mxu_pkg::array_n)-1:0]  cmd_row,
  input  logic [mxu_pkg::addr_w-1:0]           cmd_base,
  input  logic                                 wave_done,
  output logic                                 load_en,
  output logic [$clog2(mxu_pkg::array_n)-1:0]  load_row,
  output logic                                 row_valid,
  output logic                                 wave_start,
  output logic [mxu_pkg::addr_w-1:0]           base_addr,
  output logic                                 cmd_seen,
  output logic                                 busy
);

  mxu_ctrl_pkg::ctrl_state_e state;
  logic [$clog2(2*mxu_pkg::array_n)-1:0] cnt; // cycles since the first stream strobe
  logic stream_ok;

  // stream rows are taken when idle (first row) or during the stream phase
  assign stream_ok = cmd_valid && (cmd_op == mxu_ctrl_pkg::op_stream) &&
                     (state == mxu_ctrl_pkg::st_idle || state == mxu_ctrl_pkg::st_stream);

  assign load_en    = cmd_valid && (cmd_op == mxu_ctrl_pkg::op_load_w) &&
                      (state == mxu_ctrl_pkg::st_idle); // no weight change mid-compute
  assign load_row   = cmd_row;
  assign row_valid  = stream_ok;
  assign cmd_seen   = load_en || stream_ok;
  assign busy       = (state != mxu_ctrl_pkg::st_idle);

  // row 0 column 0 is in the bottom register one cycle after this
  assign wave_start = (state == mxu_ctrl_pkg::st_drain) && (cnt == mxu_pkg::array_n + 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mxu_ctrl_pkg::st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        mxu_ctrl_pkg::st_idle: begin
          if (stream_ok) begin
            state <= mxu_ctrl_pkg::st_stream;
            cnt   <= 1;
          end
        end
        mxu_ctrl_pkg::st_stream: begin
          cnt <= cnt + 1'b1; // a missing strobe just feeds a zero row
          if (cnt == mxu_pkg::array_n - 1) state <= mxu_ctrl_pkg::st_drain;
        end
        mxu_ctrl_pkg::st_drain: begin
          cnt <= cnt + 1'b1;
          if (wave_start) state <= mxu_ctrl_pkg::st_done;
        end
        default: begin
          if (wave_done) state <= mxu_ctrl_pkg::st_idle; // last column written
        end
      endcase
    end
  end

  // result base row, taken with the first activation row
  always_ff @(posedge clk) begin
    if (stream_ok && state == mxu_ctrl_pkg::st_idle) base_addr <= cmd_base;
  end

endmodule

/* hdl/result_wr_if.sv */
// Result write bus
// per-column write port from the result writer into the column memories,
// plus a clear strobe that zeroes the whole result store

interface result_wr_if;

  logic [mxu_pkg::array_n-1:0]                    wr_en;   // one enable per column
  logic [mxu_pkg::array_n-1:0][mxu_pkg::addr_w-1:0] wr_addr; // row address per column
  mxu_pkg::acc_row_t                              wr_data; // bottom row of the array
  logic                                           clear;   // zero every row

  modport writer (
    output wr_en,
    output wr_addr,
    output wr_data,
    output clear
  );

  modport memory (
    input wr_en,
    input wr_addr,
    input wr_data,
    input clear
  );

endinterface

/* hdl/mxu_ctrl_pkg.sv */
// MXU control package
// command opcodes seen on the host port and the sequencer states

package mxu_ctrl_pkg;

  // host command opcodes
  typedef enum logic {
    op_load_w = 1'b0, // load one weight row
    op_stream = 1'b1  // stream one activation row
  } mxu_op_e;

  // sequencer states
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_stream = 2'd1, // taking the four activation rows
    st_drain  = 2'd2, // waiting for row 0 to reach the bottom
    st_done   = 2'd3  // write wavefront in flight
  } ctrl_state_e;

endpackage

/* hdl/mxu_pkg.sv */
// MXU datapath package
// array size, element widths and the row types shared by the
// systolic array, the skew stage and the result memory

package mxu_pkg;

  // array dimension, rows and columns alike
  localparam int array_n = 4;

  // activations and weights are signed bytes
  localparam int data_w = 8;

  // partial sums and results
  localparam int acc_w = 24;

  // result memory row address, 16 rows per column
  localparam int addr_w = 4;

  // one activation or weight row, element i at [i]
  typedef logic signed [array_n-1:0][data_w-1:0] data_row_t;

  // one result row, column j at [j]
  typedef logic signed [array_n-1:0][acc_w-1:0] acc_row_t;

endpackage
